// File: thor_pkg.sv
// Thor integer execution unit, shared definitions
// Opcodes, BCD and bitfield sub-operation codes, datapath width and
// the credit depths used by the issue and result sides
package thor_pkg;

	// ========================================================================
	// Datapath
	// ========================================================================
	localparam int data_w = 64;
	localparam int op_w = 8;

	// ========================================================================
	// Opcodes
	// ========================================================================
	localparam logic [7:0] op_ldi = 8'h6F;
	// Add and subtract, register and immediate forms
	localparam logic [7:0] op_add = 8'h04;
	localparam logic [7:0] op_sub = 8'h05;
	localparam logic [7:0] op_addi = 8'h48;
	localparam logic [7:0] op_subi = 8'h49;
	// Scaled adds, a shifted left then plus b
	localparam logic [7:0] op_add2u = 8'h08;
	localparam logic [7:0] op_add4u = 8'h09;
	localparam logic [7:0] op_add8u = 8'h0A;
	localparam logic [7:0] op_add16u = 8'h0B;
	// Single operand
	localparam logic [7:0] op_neg = 8'h10;
	localparam logic [7:0] op_not = 8'h11;
	localparam logic [7:0] op_mov = 8'h12;
	// Logic, register form
	localparam logic [7:0] op_and = 8'h20;
	localparam logic [7:0] op_or = 8'h21;
	localparam logic [7:0] op_eor = 8'h22;
	localparam logic [7:0] op_nand = 8'h23;
	localparam logic [7:0] op_nor = 8'h24;
	localparam logic [7:0] op_enor = 8'h25;
	// Logic, immediate form
	localparam logic [7:0] op_andi = 8'h53;
	localparam logic [7:0] op_ori = 8'h54;
	localparam logic [7:0] op_eori = 8'h55;
	// Flag words
	localparam logic [7:0] op_cmp = 8'h30;
	localparam logic [7:0] op_cmpi = 8'h31;
	localparam logic [7:0] op_tst = 8'h32;
	// Sign bit only, no rounding
	localparam logic [7:0] op_fneg = 8'h14;
	localparam logic [7:0] op_fabs = 8'h15;
	localparam logic [7:0] op_mux = 8'h72;
	// Shifts and rotates
	localparam logic [7:0] op_shl = 8'h58;
	localparam logic [7:0] op_shr = 8'h59;
	localparam logic [7:0] op_shru = 8'h5A;
	localparam logic [7:0] op_rol = 8'h5B;
	localparam logic [7:0] op_ror = 8'h5C;
	localparam logic [7:0] op_bitfield = 8'h6A;
	localparam logic [7:0] op_bcd = 8'hF5;
	// Address generation
	localparam logic [7:0] op_lea = 8'h4C;
	localparam logic [7:0] op_jsr = 8'hA2;

	// ========================================================================
	// Sub-operation codes
	// ========================================================================
	// BCD select, immediate bits 7..0
	localparam logic [7:0] bcd_add = 8'h00;
	localparam logic [7:0] bcd_sub = 8'h01;
	localparam logic [7:0] bcd_mul = 8'h02;
	// Bitfield select, immediate bits 15..12
	localparam logic [3:0] bf_extu = 4'd0;
	localparam logic [3:0] bf_exts = 4'd1;
	localparam logic [3:0] bf_clr = 4'd2;
	localparam logic [3:0] bf_set = 4'd3;
	localparam logic [3:0] bf_ins = 4'd4;

	// Marker for an unknown opcode or BCD code
	localparam logic [63:0] bad_result = 64'hDEAD_DEAD_DEAD_DEAD;

	// ========================================================================
	// Flow control
	// ========================================================================
	localparam int queue_depth = 4;
	localparam int res_credits = 2;
	localparam int cnt_w = 3;

endpackage

// File: thor_shifter.sv
// Thor shifter
// Left shift, arithmetic and logical right shift, and rotates in
// both directions. Amount comes from operand b bits 5..0
module thor_shifter (
	input  logic [thor_pkg::op_w-1:0]   op,
	input  logic [thor_pkg::data_w-1:0] a,
	input  logic [thor_pkg::data_w-1:0] b,
	output logic [thor_pkg::data_w-1:0] o
);
	import thor_pkg::*;

	logic [5:0]            amt;
	logic [2*data_w-1:0]   rol_w;
	logic [2*data_w-1:0]   ror_w;

	assign amt = b[5:0];

	// Doubled operand, so a plain shift wraps the bits around
	assign rol_w = {a, a} << amt;
	assign ror_w = {a, a} >> amt;

	always_comb begin
		case (op)
			op_shl:
				o = a << amt;
			// Sign fill
			op_shr:
				o = $signed(a) >>> amt;
			op_shru:
				o = a >> amt;
			// Upper half holds the rotated word
			op_rol:
				o = rol_w[2*data_w-1:data_w];
			op_ror:
				o = ror_w[data_w-1:0];
			default:
				o = '0;
		endcase
	end

endmodule

// File: thor_bitfield.sv
// Thor bitfield unit
// Extract (zero or sign filled), clear, set and insert on a field
// given by offset and width in a 16-bit control word
module thor_bitfield (
	input  logic [thor_pkg::data_w-1:0] a,
	input  logic [thor_pkg::data_w-1:0] b,
	input  logic [15:0]                 ctl,
	output logic [thor_pkg::data_w-1:0] o
);
	import thor_pkg::*;

	logic [5:0]        offset;
	logic [5:0]        wm1;
	logic [3:0]        sub;
	logic [6:0]        top_sum;
	logic [5:0]        top;
	logic [data_w-1:0] low_mask;
	logic [data_w-1:0] mask;
	logic [data_w-1:0] field;

	// Control word fields
	assign offset = ctl[5:0];
	assign wm1 = ctl[11:6];
	assign sub = ctl[15:12];

	// Width ones at the bottom, then moved up; bits past 63 fall off
	assign low_mask = {data_w{1'b1}} >> (6'd63 - wm1);
	assign mask = low_mask << offset;

	// Highest bit actually inside the field, after the cut at 63
	assign top_sum = {1'b0, offset} + {1'b0, wm1};
	assign top = top_sum[6] ? 6'd63 : top_sum[5:0];

	// Right aligned field, zero filled
	assign field = (a & mask) >> offset;

	always_comb begin
		case (sub)
			bf_extu: o = field;
			// Fill above the truncated field with its top bit
			bf_exts: o = field | (a[top] ? ~(mask >> offset) : '0);
			bf_clr:  o = a & ~mask;
			bf_set:  o = a | mask;
			bf_ins:  o = (a & ~mask) | ((b << offset) & mask);
			default: o = a;
		endcase
	end

endmodule

// File: thor_bcd.sv
// Thor BCD unit
// Two packed BCD digits per operand. Add gives three digits with the
// carry in bit 8, subtract gives the difference modulo 100, multiply
// gives four digits
module thor_bcd (
	input  logic [7:0]  a,
	input  logic [7:0]  b,
	input  logic [7:0]  sel,
	output logic [15:0] o
);
	import thor_pkg::*;

	logic [14:0] av;
	logic [14:0] bv;
	logic [14:0] sum_bin;
	logic [14:0] diff_bin;
	logic [14:0] prod_bin;

	// Packed digit pair to binary
	function automatic logic [14:0] to_bin(input logic [7:0] d);
		return 15'(d[7:4]) * 15'd10 + 15'(d[3:0]);
	endfunction

	// Binary back to four packed digits
	function automatic logic [15:0] to_bcd(input logic [14:0] v);
		return {4'(v / 1000), 4'((v / 100) % 10), 4'((v / 10) % 10), 4'(v % 10)};
	endfunction

	assign av = to_bin(a);
	assign bv = to_bin(b);

	// ========================================================================
	// Decimal arithmetic in binary
	// ========================================================================
	assign sum_bin = av + bv;

	// Offset by 200 keeps the difference positive before the modulo
	assign diff_bin = (av + 15'd200 - bv) % 15'd100;

	assign prod_bin = av * bv;

	// Unknown select gives zero here
	// thor_alu flags it as bad_result
	always_comb begin
		case (sel)
			// Hundreds digit is 0 or 1, so it lands in bit 8
			bcd_add: o = to_bcd(sum_bin);
			bcd_sub: o = to_bcd(diff_bin);
			bcd_mul: o = to_bcd(prod_bin);
			default: o = '0;
		endcase
	end

endmodule

// File: thor_alu.sv
// Thor ALU
// Combinational opcode decode and result selection. Shifts, bitfields
// and BCD come from their own sub-units; all else is computed here.
// An unknown opcode or BCD code gives bad_result
module thor_alu (
	input  logic [thor_pkg::op_w-1:0]   op,
	input  logic [thor_pkg::data_w-1:0] a,
	input  logic [thor_pkg::data_w-1:0] b,
	input  logic [thor_pkg::data_w-1:0] c,
	input  logic [thor_pkg::data_w-1:0] imm,
	input  logic [thor_pkg::data_w-1:0] pc,
	input  logic [3:0]                  insn_size,
	output logic [thor_pkg::data_w-1:0] o
);
	import thor_pkg::*;

	logic [data_w-1:0] shft_o;
	logic [data_w-1:0] bf_o;
	logic [15:0]       bcd_o;

	// ========================================================================
	// Sub-units
	// ========================================================================
	thor_shifter u_shft (
		.op (op),
		.a  (a),
		.b  (b),
		.o  (shft_o)
	);

	// Control word sits in the low 16 bits of the immediate
	thor_bitfield u_bf (
		.a   (a),
		.b   (b),
		.ctl (imm[15:0]),
		.o   (bf_o)
	);

	// Low bytes only
	thor_bcd u_bcd (
		.a   (a[7:0]),
		.b   (b[7:0]),
		.sel (imm[7:0]),
		.o   (bcd_o)
	);

	// ========================================================================
	// Result select
	// ========================================================================
	always_comb begin
		case (op)
			op_ldi:    o = imm;
			op_add:    o = a + b;
			op_sub:    o = a - b;
			op_addi:   o = a + imm;
			op_subi:   o = a - imm;
			// Scaled index adds
			op_add2u:  o = (a << 1) + b;
			op_add4u:  o = (a << 2) + b;
			op_add8u:  o = (a << 3) + b;
			op_add16u: o = (a << 4) + b;
			op_neg:    o = -a;
			op_not:    o = ~a;
			op_mov:    o = a;
			// Logic, register form
			op_and:    o = a & b;
			op_or:     o = a | b;
			op_eor:    o = a ^ b;
			op_nand:   o = ~(a & b);
			op_nor:    o = ~(a | b);
			op_enor:   o = ~(a ^ b);
			// Logic, immediate form
			op_andi:   o = a & imm;
			op_ori:    o = a | imm;
			op_eori:   o = a ^ imm;
			// Flags: bit 0 equal, bit 1 signed less, bit 2 unsigned less
			op_cmp: begin
				o = '0;
				o[0] = a == b;
				o[1] = $signed(a) < $signed(b);
				o[2] = a < b;
			end
			op_cmpi: begin
				o = '0;
				o[0] = a == imm;
				o[1] = $signed(a) < $signed(imm);
				o[2] = a < imm;
			end
			// Flags: bit 0 zero, bit 1 negative
			op_tst: begin
				o = '0;
				o[0] = a == '0;
				o[1] = a[data_w-1];
			end
			// Float sign bit only
			op_fneg:   o = {~a[data_w-1], a[data_w-2:0]};
			op_fabs:   o = {1'b0, a[data_w-2:0]};
			// Per bit: a set picks b, a clear picks c
			op_mux:    o = (a & b) | (~a & c);
			op_shl, op_shr, op_shru, op_rol, op_ror:
				o = shft_o;
			op_bitfield:
				o = bf_o;
			op_bcd: begin
				if (imm[7:0] == bcd_add || imm[7:0] == bcd_sub || imm[7:0] == bcd_mul)
					o = {{(data_w - 16){1'b0}}, bcd_o};
				else
					o = bad_result;
			end
			// Effective address
			op_lea:    o = a + imm;
			// Return address, past the current instruction
			op_jsr:    o = pc + {{(data_w - 4){1'b0}}, insn_size};
			default:   o = bad_result;
		endcase
	end

endmodule

// File: thor_result_queue.sv
// Thor result queue
// In-order FIFO of ALU results. Sends the head while downstream credit
// is held; every send returns one issue credit upstream
module thor_result_queue (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        push,
	input  logic [thor_pkg::data_w-1:0] push_data,
	input  logic                        res_credit,
	output logic                        res_valid,
	output logic [thor_pkg::data_w-1:0] result,
	output logic                        issue_credit
);
	import thor_pkg::*;

	logic [data_w-1:0]              mem [queue_depth];
	logic [$clog2(queue_depth)-1:0] wr_ptr;
	logic [$clog2(queue_depth)-1:0] rd_ptr;
	logic [cnt_w-1:0]               count;
	logic [cnt_w-1:0]               credits;
	logic                           pop;

	// Head is visible as soon as there is an entry and a credit
	assign res_valid = (count != '0) && (credits != '0);
	assign result = mem[rd_ptr];
	assign pop = res_valid;

	// A freed slot goes straight back upstream
	assign issue_credit = pop;

	// Storage, no reset
	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	// ========================================================================
	// Pointers, occupancy and downstream credit
	// ========================================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credits <= cnt_w'(res_credits);
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			// Upstream credits keep push from ever hitting a full queue
			count <= count + cnt_w'(push) - cnt_w'(pop);
			credits <= credits + cnt_w'(res_credit) - cnt_w'(pop);
		end
	end

endmodule

// File: thor_alu_unit.sv
// Thor integer execution unit, top level
// Issue lands in the operand register, the ALU evaluates it in the
// following cycle, and the result queue returns it in issue order
module thor_alu_unit (
	input  logic                        clk,
	input  logic                        rst,
	// Issue side
	input  logic                        issue_valid,
	input  logic [thor_pkg::op_w-1:0]   issue_op,
	input  logic [thor_pkg::data_w-1:0] arg_a,
	input  logic [thor_pkg::data_w-1:0] arg_b,
	input  logic [thor_pkg::data_w-1:0] arg_c,
	input  logic [thor_pkg::data_w-1:0] arg_i,
	input  logic [thor_pkg::data_w-1:0] pc,
	input  logic [3:0]                  insn_size,
	output logic                        issue_credit,
	// Result side
	output logic                        res_valid,
	output logic [thor_pkg::data_w-1:0] result,
	input  logic                        res_credit
);
	import thor_pkg::*;

	// Operand register
	logic              opr_valid;
	logic [op_w-1:0]   opr_op;
	logic [data_w-1:0] opr_a;
	logic [data_w-1:0] opr_b;
	logic [data_w-1:0] opr_c;
	logic [data_w-1:0] opr_i;
	logic [data_w-1:0] opr_pc;
	logic [3:0]        opr_size;
	logic [data_w-1:0] alu_o;

	// Never stalls: each issue already owns a queue slot
	always_ff @(posedge clk) begin
		if (rst)
			opr_valid <= 1'b0;
		else
			opr_valid <= issue_valid;
	end

	// Payload only loads on an issue
	always_ff @(posedge clk) begin
		if (issue_valid) begin
			opr_op <= issue_op;
			opr_a <= arg_a;
			opr_b <= arg_b;
			opr_c <= arg_c;
			opr_i <= arg_i;
			opr_pc <= pc;
			opr_size <= insn_size;
		end
	end

	thor_alu u_alu (
		.op        (opr_op),
		.a         (opr_a),
		.b         (opr_b),
		.c         (opr_c),
		.imm       (opr_i),
		.pc        (opr_pc),
		.insn_size (opr_size),
		.o         (alu_o)
	);

	thor_result_queue u_rq (
		.clk          (clk),
		.rst          (rst),
		.push         (opr_valid),
		.push_data    (alu_o),
		.res_credit   (res_credit),
		.res_valid    (res_valid),
		.result       (result),
		.issue_credit (issue_credit)
	);

endmodule

// File: tb_checker.sv
// Thor execution unit checker
// Watches the issue and result ports, predicts every result from the
// operation rules, and compares the results in issue order. Also tracks
// both credit loops and prints the closing count line on request
module tb_checker (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        issue_valid,
	input  logic [thor_pkg::op_w-1:0]   issue_op,
	input  logic [thor_pkg::data_w-1:0] arg_a,
	input  logic [thor_pkg::data_w-1:0] arg_b,
	input  logic [thor_pkg::data_w-1:0] arg_c,
	input  logic [thor_pkg::data_w-1:0] arg_i,
	input  logic [thor_pkg::data_w-1:0] pc,
	input  logic [3:0]                  insn_size,
	input  logic                        issue_credit,
	input  logic                        res_valid,
	input  logic [thor_pkg::data_w-1:0] result,
	input  logic                        res_credit,
	input  logic                        report_req,
	output int                          pend_cnt,
	output int                          fail_cnt
);
	import thor_pkg::*;

	logic [63:0] exp_q [$];
	logic [7:0]  op_q [$];
	int          cyc_q [$];
	logic [63:0] exp_v;
	logic [7:0]  exp_op;
	int          iss_cyc;
	int          cyc, up_cred, dn_cred;
	int          err_cnt, brk_cnt, chk_cnt;
	logic        seen_issue;

	// ========================================================================
	// Reference model
	// ========================================================================
	// Field of width wm1+1 at offset, cut off at bit 63
	function automatic logic [63:0] ref_bitfield(input logic [63:0] a, b, input logic [15:0] ctl);
		logic [63:0] r;
		logic [3:0]  sub;
		int          off, n;
		off = int'(ctl[5:0]);
		n = int'(ctl[11:6]) + 1;
		sub = ctl[15:12];
		if (off + n > 64)
			n = 64 - off;
		if (sub == bf_extu || sub == bf_exts) begin
			r = '0;
			for (int k = 0; k < 64; k++) begin
				if (k < n)
					r[6'(k)] = a[6'(off + k)];
				else if (sub == bf_exts)
					r[6'(k)] = a[6'(off + n - 1)];
			end
		end else begin
			// Unknown sub-operation leaves a as it is
			r = a;
			for (int k = 0; k < n; k++) begin
				case (sub)
					bf_clr:  r[6'(off + k)] = 1'b0;
					bf_set:  r[6'(off + k)] = 1'b1;
					bf_ins:  r[6'(off + k)] = b[6'(k)];
					default: ;
				endcase
			end
		end
		return r;
	endfunction

	// Decimal arithmetic on two packed digits, four packed digits out
	function automatic logic [63:0] ref_bcd(input logic [7:0] x, y, sel);
		logic [63:0] r;
		int          xv, yv, v;
		xv = int'(x[7:4]) * 10 + int'(x[3:0]);
		yv = int'(y[7:4]) * 10 + int'(y[3:0]);
		case (sel)
			bcd_add: v = xv + yv;
			bcd_sub: v = (xv - yv + 100) % 100;
			bcd_mul: v = xv * yv;
			default: return bad_result;
		endcase
		r = '0;
		r[3:0] = 4'(v % 10);
		r[7:4] = 4'((v / 10) % 10);
		r[11:8] = 4'((v / 100) % 10);
		r[15:12] = 4'(v / 1000);
		return r;
	endfunction

	function automatic logic [63:0] ref_result(input logic [7:0] op,
			input logic [63:0] a, b, c, i, p, input logic [3:0] sz);
		logic [63:0] r;
		int          amt;
		amt = int'(b[5:0]);
		r = '0;
		case (op)
			op_ldi:             r = i;
			op_add:             r = a + b;
			op_sub:             r = a - b;
			op_addi, op_lea:    r = a + i;
			op_subi:            r = a - i;
			op_add2u:           r = a * 64'd2 + b;
			op_add4u:           r = a * 64'd4 + b;
			op_add8u:           r = a * 64'd8 + b;
			op_add16u:          r = a * 64'd16 + b;
			op_neg:             r = 64'd0 - a;
			op_not, op_nand:    r = (op == op_not) ? ~a : ~(a & b);
			op_mov:             r = a;
			op_and:             r = a & b;
			op_or:              r = a | b;
			op_eor:             r = a ^ b;
			op_nor:             r = ~(a | b);
			op_enor:            r = ~(a ^ b);
			op_andi:            r = a & i;
			op_ori:             r = a | i;
			op_eori:            r = a ^ i;
			op_cmp:             r = {61'b0, a < b, $signed(a) < $signed(b), a == b};
			op_cmpi:            r = {61'b0, a < i, $signed(a) < $signed(i), a == i};
			op_tst:             r = {62'b0, a[63], a == '0};
			op_fneg:            r = a ^ {1'b1, 63'b0};
			op_fabs:            r = a & {1'b0, {63{1'b1}}};
			op_shl:             r = a << amt;
			op_shr:             r = $signed(a) >>> amt;
			op_shru:            r = a >> amt;
			op_bitfield:        r = ref_bitfield(a, b, i[15:0]);
			op_bcd:             r = ref_bcd(a[7:0], b[7:0], i[7:0]);
			op_jsr:             r = p + 64'(sz);
			op_mux, op_rol, op_ror: begin
				for (int k = 0; k < 64; k++) begin
					if (op == op_mux)
						r[6'(k)] = a[6'(k)] ? b[6'(k)] : c[6'(k)];
					else if (op == op_rol)
						r[6'(k + amt)] = a[6'(k)];
					else
						r[6'(k)] = a[6'(k + amt)];
				end
			end
			default:            r = bad_result;
		endcase
		return r;
	endfunction

	// ========================================================================
	// Compare and credit tracking, sampled at the rising edge
	// ========================================================================
	always @(posedge clk) begin
		if (rst) begin
			exp_q.delete();
			op_q.delete();
			cyc_q.delete();
			cyc = 0;
			up_cred = queue_depth;
			dn_cred = res_credits;
			seen_issue = 1'b0;
		end else begin
			cyc = cyc + 1;
			// Nothing may leave before the first issue
			if (!seen_issue && (res_valid || issue_credit)) begin
				$display("credit breach at %0t: output active before any issue", $time);
				brk_cnt++;
			end
			if (res_valid) begin
				if (dn_cred <= 0) begin
					$display("credit breach at %0t: result sent with no downstream credit", $time);
					brk_cnt++;
				end
				if (exp_q.size() == 0) begin
					$display("protocol breach at %0t: result sent with nothing outstanding", $time);
					brk_cnt++;
				end else begin
					exp_v = exp_q.pop_front();
					exp_op = op_q.pop_front();
					iss_cyc = cyc_q.pop_front();
					if (cyc - iss_cyc < 2) begin
						$display("latency breach at %0t: result only %0d cycles after issue",
							$time, cyc - iss_cyc);
						brk_cnt++;
					end
					if (result !== exp_v) begin
						$display("error at %0t: op %02h expected %016h got %016h",
							$time, exp_op, exp_v, result);
						err_cnt++;
					end
					chk_cnt++;
				end
			end
			if (issue_valid) begin
				if (up_cred <= 0) begin
					$display("credit breach at %0t: issue made without an issue credit", $time);
					brk_cnt++;
				end
				up_cred = up_cred - 1;
				exp_q.push_back(ref_result(issue_op, arg_a, arg_b, arg_c, arg_i, pc, insn_size));
				op_q.push_back(issue_op);
				cyc_q.push_back(cyc);
				seen_issue = 1'b1;
			end
			if (issue_credit)
				up_cred = up_cred + 1;
			// Returned credits may never exceed the queue slots
			if (up_cred > queue_depth) begin
				$display("credit breach at %0t: unit returned more issue credits than it owed",
					$time);
				brk_cnt++;
			end
			dn_cred = dn_cred + int'(res_credit) - int'(res_valid);
		end
		pend_cnt = exp_q.size();
	end

	// Results still queued at the end count as lost
	assign fail_cnt = err_cnt + brk_cnt + pend_cnt;

	always @(posedge report_req) begin
		$display("checked %0d results: %0d value errors, %0d protocol errors, %0d missing",
			chk_cnt, err_cnt, brk_cnt, pend_cnt);
	end

endmodule

// File: tb_thor_alu_unit.sv
// Thor execution unit testbench
// Clock, reset, random issue stimulus and downstream credit pulses.
// Issues only while an issue credit is held; checking is in tb_checker
module tb_thor_alu_unit;
	import thor_pkg::*;

	// ========================================================================
	// Run length
	// ========================================================================
	localparam int n_rand = 150;
	localparam int n_shift = 40;
	localparam int n_bf = 48;
	localparam int n_bcd = 38;
	localparam int n_stall = 30;
	localparam int n_ops = n_rand + n_shift + n_bf + n_bcd + n_stall;
	localparam int max_cycles = n_ops * 20 + 200;
	// Cycles allowed for the last results to leave
	localparam int drain_limit = 200;

	logic        clk, rst, issue_valid, issue_credit, res_valid, res_credit;
	logic [7:0]  issue_op;
	logic [63:0] arg_a, arg_b, arg_c, arg_i, pc, result, opnd_a, opnd_b, imm;
	logic [3:0]  insn_size, sub;
	logic [5:0]  off, wm1;
	logic        credit_en, report_req;
	int          n_issued, n_returned, n_pulses, n_sent, pend_cnt, fail_cnt, cyc;

	thor_alu_unit u_dut (
		.clk(clk), .rst(rst), .issue_valid(issue_valid), .issue_op(issue_op),
		.arg_a(arg_a), .arg_b(arg_b), .arg_c(arg_c), .arg_i(arg_i), .pc(pc),
		.insn_size(insn_size), .issue_credit(issue_credit), .res_valid(res_valid),
		.result(result), .res_credit(res_credit)
	);

	tb_checker u_chk (
		.clk(clk), .rst(rst), .issue_valid(issue_valid), .issue_op(issue_op),
		.arg_a(arg_a), .arg_b(arg_b), .arg_c(arg_c), .arg_i(arg_i), .pc(pc),
		.insn_size(insn_size), .issue_credit(issue_credit), .res_valid(res_valid),
		.result(result), .res_credit(res_credit), .report_req(report_req),
		.pend_cnt(pend_cnt), .fail_cnt(fail_cnt)
	);

	always #50 clk = ~clk;

	function automatic logic [63:0] rand_word();
		return {$urandom, $urandom};
	endfunction

	// Arithmetic, logic, flag, float, mux, address and load-immediate ops
	function automatic logic [7:0] pick_basic_op(input int k);
		logic [7:0] tbl [29] = '{op_ldi, op_add, op_sub, op_addi, op_subi, op_add2u,
			op_add4u, op_add8u, op_add16u, op_neg, op_not, op_mov, op_and, op_or, op_eor,
			op_nand, op_nor, op_enor, op_andi, op_ori, op_eori, op_cmp, op_cmpi, op_tst,
			op_fneg, op_fabs, op_mux, op_lea, op_jsr};
		return tbl[k % 29];
	endfunction

	function automatic logic [7:0] pick_shift_op(input int k);
		logic [7:0] tbl [5] = '{op_shl, op_shr, op_shru, op_rol, op_ror};
		return tbl[k % 5];
	endfunction

	// Upstream credit count, returns land on the rising edge
	function automatic int issue_credits_held();
		return queue_depth - n_issued + n_returned;
	endfunction

	// One issue cycle, called at a falling edge, waits for a credit
	task automatic send_op(input logic [7:0] op, input logic [63:0] a, b, c, i);
		while (issue_credits_held() <= 0)
			@(negedge clk);
		issue_valid = 1'b1;
		issue_op = op;
		arg_a = a;
		arg_b = b;
		arg_c = c;
		arg_i = i;
		pc = rand_word();
		insn_size = 4'($urandom);
		n_issued = n_issued + 1;
		@(negedge clk);
		issue_valid = 1'b0;
	endtask

	always @(posedge clk) begin
		if (rst) begin
			n_returned <= 0;
			n_sent <= 0;
		end else begin
			n_returned <= n_returned + int'(issue_credit);
			n_sent <= n_sent + int'(res_valid);
		end
	end

	// Random downstream credits, held at most queue_depth ahead
	always @(negedge clk) begin
		res_credit = 1'b0;
		if (!rst && credit_en && res_credits + n_pulses - n_sent < queue_depth
				&& $urandom % 3 == 0) begin
			res_credit = 1'b1;
			n_pulses = n_pulses + 1;
		end
	end

	// Watchdog
	initial begin
		for (cyc = 0; cyc < max_cycles; cyc++)
			@(posedge clk);
		$display("timeout: results still outstanding after %0d cycles", max_cycles);
		$display(">>> FAIL");
		$finish;
	end

	// ========================================================================
	// Stimulus
	// ========================================================================
	initial begin
		void'($urandom(47));
		clk = 1'b0;
		rst = 1'b1;
		issue_valid = 1'b0;
		issue_op = '0;
		{arg_a, arg_b, arg_c, arg_i, pc} = '0;
		insn_size = '0;
		res_credit = 1'b0;
		credit_en = 1'b0;
		report_req = 1'b0;
		n_issued = 0;
		n_pulses = 0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		// Quiet stretch, outputs must stay low
		repeat (5) @(negedge clk);
		credit_en = 1'b1;
		// Mixed ops, zero and equal operands now and then for the flag words
		for (int k = 0; k < n_rand; k++) begin
			opnd_a = ($urandom % 8 == 0) ? '0 : rand_word();
			opnd_b = ($urandom % 4 == 0) ? opnd_a : rand_word();
			imm = ($urandom % 4 == 0) ? opnd_a : rand_word();
			send_op(pick_basic_op(int'($urandom % 29)), opnd_a, opnd_b, rand_word(), imm);
		end
		// Amounts 0, 1, 63, then random
		for (int k = 0; k < n_shift; k++) begin
			opnd_b = rand_word();
			if (k < 20)
				opnd_b[5:0] = (k < 5) ? 6'd0 : (k < 10) ? 6'd1 : (k < 15) ? 6'd63 : opnd_b[5:0];
			send_op(pick_shift_op(k), rand_word(), opnd_b, rand_word(), rand_word());
		end
		// Every sub-operation and one unknown, odd rounds run past bit 63
		for (int k = 0; k < n_bf; k++) begin
			sub = (k % 6 == 5) ? 4'd9 : 4'(k % 6);
			off = ((k / 6) % 2 == 1) ? 6'(40 + $urandom % 24) : 6'($urandom);
			wm1 = ((k / 6) % 2 == 1) ? 6'(30 + $urandom % 34) : 6'($urandom);
			imm = rand_word();
			imm[15:0] = {sub, wm1, off};
			send_op(op_bitfield, rand_word(), rand_word(), rand_word(), imm);
		end
		// Valid digit pairs, then unknown BCD codes and unknown opcodes
		for (int k = 0; k < n_bcd; k++) begin
			opnd_a = rand_word();
			opnd_b = rand_word();
			opnd_a[7:0] = {4'($urandom % 10), 4'($urandom % 10)};
			opnd_b[7:0] = {4'($urandom % 10), 4'($urandom % 10)};
			imm = rand_word();
			imm[7:0] = (k < 30) ? 8'(k % 3) : 8'(k + 3);
			// Opcodes E0 to E3 are not decoded
			send_op((k < 34) ? op_bcd : 8'hE0 + 8'(k - 34), opnd_a, opnd_b, rand_word(), imm);
		end
		// Withhold downstream credits until the queue fills
		credit_en = 1'b0;
		for (int k = 0; k < 10; k++) begin
			if (issue_credits_held() > 0)
				send_op(pick_basic_op(int'($urandom % 29)), rand_word(), rand_word(),
					rand_word(), rand_word());
			else
				@(negedge clk);
		end
		repeat (20) @(negedge clk);
		credit_en = 1'b1;
		for (int k = 10; k < n_stall; k++)
			send_op(pick_basic_op(int'($urandom % 29)), rand_word(), rand_word(),
				rand_word(), rand_word());
		// Drain, then a few idle cycles to catch stray results
		for (int k = 0; k < drain_limit && pend_cnt != 0; k++)
			@(negedge clk);
		repeat (10) @(negedge clk);
		report_req = 1'b1;
		@(negedge clk);
		if (fail_cnt == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// File: compile.f
thor_pkg.sv
thor_shifter.sv
thor_bitfield.sv
thor_bcd.sv
thor_alu.sv
thor_result_queue.sv
thor_alu_unit.sv
tb_checker.sv
tb_thor_alu_unit.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_thor_alu_unit
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
PASS_MSG  := >>> PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
